/* verification/alu_vectors.txt */
// op a b flags_in ctrl(error,thread,except,except_thread) then expected result flags status sets_flags ret_en
// flags are C O A S Z P from bit 5 down, status 2 done and 1 exception, ffff in the op column ends the list
0c00 0000000000000001 0000000000000002 00 0 0000000000000003 01 2 1 1
0c00 ffffffffffffffff 0000000000000001 00 0 0000000000000000 2b 2 1 1
0c00 7fffffffffffffff 0000000000000001 00 0 8000000000000000 1d 2 1 1
0800 12345678ffffffff 0000000000000001 00 0 0000000000000000 2b 2 1 1
0800 000000007ffffff0 ffffffff00000010 00 0 0000000080000000 15 2 1 1
0c01 0000000000000005 0000000000000003 00 0 0000000000000002 20 2 1 1
0c01 0000000000000003 0000000000000005 00 0 fffffffffffffffe 0c 2 1 1
0c01 0000000000001234 0000000000001234 00 0 0000000000000000 23 2 1 1
0c01 8000000000000000 0000000000000001 00 0 7fffffffffffffff 39 2 1 1
0801 ffffffff00000001 0000000000000002 00 0 00000000ffffffff 0d 2 1 1
0c04 ff00ff00f0f0f0f0 0ff00ff0ffff0f0f 00 0 0f000f00f0f00000 01 2 1 1
0c05 8000000000000000 0000000000000007 00 0 8000000000000007 04 2 1 1
0c06 5a5a5a5a5a5a5a5a 5a5a5a5a5a5a5a5a 00 0 0000000000000000 03 2 1 1
0c07 0000000000000000 ffffffffffffff00 00 0 00000000000000ff 01 2 1 1
0804 ffffffffffffffff ffffffff80000001 00 0 0000000080000001 04 2 1 1
0805 0000000000000000 abcdef0100000080 00 0 0000000000000080 00 2 1 1
0806 fffffffffffffff0 0000000f0000000f 00 0 00000000ffffffff 05 2 1 1
0807 1234567800000000 00000000ffffffff 00 0 0000000000000000 03 2 1 1
1c00 ffffffffffffffff 0000000000000001 00 0 0000000000000000 00 2 0 1
1804 00000000000000ff 000000000000000f 00 0 000000000000000f 00 2 0 1
0010 5555555555555555 123456789abcdef0 00 0 00000000000000f0 00 2 0 1
0011 5555555555555555 123456789abcdef0 00 0 fffffffffffffff0 00 2 0 1
0011 5555555555555555 ffffffffffffff7f 00 0 000000000000007f 00 2 0 1
0410 5555555555555555 123456789abcdef0 00 0 000000000000def0 00 2 0 1
0411 5555555555555555 123456789abcdef0 00 0 ffffffffffffdef0 00 2 0 1
0810 5555555555555555 123456789abcdef0 00 0 000000009abcdef0 00 2 0 1
0811 5555555555555555 123456789abcdef0 00 0 ffffffff9abcdef0 00 2 0 1
0c10 0000000000000001 0000000000000001 00 0 0000000000000000 0b 1 0 1
0c11 0000000000000001 0000000000000001 00 0 0000000000000000 0b 1 0 1
0000 0000000000000001 0000000000000001 00 0 0000000000000000 0b 1 0 1
0404 0000000000000001 0000000000000001 00 0 0000000000000000 0b 1 0 1
0401 0000000000000001 0000000000000001 00 0 0000000000000000 0b 1 0 1
0c3f 0000000000000001 0000000000000001 00 0 0000000000000000 0b 1 0 1
0c00 0000000000000001 0000000000000001 00 8 0000000000000000 3f 1 1 1
0c3f 0000000000000001 0000000000000001 00 8 0000000000000000 3f 1 0 1
0020 aaaaaaaaaaaaaaaa 5555555555555555 02 0 5555555555555555 00 2 0 1
0020 aaaaaaaaaaaaaaaa 5555555555555555 00 0 aaaaaaaaaaaaaaaa 00 2 0 1
0220 aaaaaaaaaaaaaaaa 5555555555555555 04 0 5555555555555555 00 2 0 1
0220 aaaaaaaaaaaaaaaa 5555555555555555 00 0 aaaaaaaaaaaaaaaa 00 2 0 1
0420 aaaaaaaaaaaaaaaa 5555555555555555 20 0 5555555555555555 00 2 0 1
0420 aaaaaaaaaaaaaaaa 5555555555555555 22 0 aaaaaaaaaaaaaaaa 00 2 0 1
0620 aaaaaaaaaaaaaaaa 5555555555555555 20 0 5555555555555555 00 2 0 1
0620 aaaaaaaaaaaaaaaa 5555555555555555 00 0 aaaaaaaaaaaaaaaa 00 2 0 1
0820 aaaaaaaaaaaaaaaa 5555555555555555 14 0 5555555555555555 00 2 0 1
0820 aaaaaaaaaaaaaaaa 5555555555555555 04 0 aaaaaaaaaaaaaaaa 00 2 0 1
0a20 aaaaaaaaaaaaaaaa 5555555555555555 00 0 5555555555555555 00 2 0 1
0a20 aaaaaaaaaaaaaaaa 5555555555555555 10 0 aaaaaaaaaaaaaaaa 00 2 0 1
0c20 aaaaaaaaaaaaaaaa 5555555555555555 10 0 5555555555555555 00 2 0 1
0c20 aaaaaaaaaaaaaaaa 5555555555555555 00 0 aaaaaaaaaaaaaaaa 00 2 0 1
0e20 aaaaaaaaaaaaaaaa 5555555555555555 01 0 5555555555555555 00 2 0 1
0e20 aaaaaaaaaaaaaaaa 5555555555555555 00 0 aaaaaaaaaaaaaaaa 00 2 0 1
0f20 aaaaaaaaaaaaaaaa 5555555555555555 3f 0 5555555555555555 00 2 0 1
0121 aaaaaaaaaaaaaaaa 5555555555555555 00 0 0000000000000001 00 2 0 1
0121 aaaaaaaaaaaaaaaa 5555555555555555 02 0 0000000000000000 00 2 0 1
0321 aaaaaaaaaaaaaaaa 5555555555555555 00 0 0000000000000001 00 2 0 1
0321 aaaaaaaaaaaaaaaa 5555555555555555 04 0 0000000000000000 00 2 0 1
0521 aaaaaaaaaaaaaaaa 5555555555555555 22 0 0000000000000001 00 2 0 1
0521 aaaaaaaaaaaaaaaa 5555555555555555 20 0 0000000000000000 00 2 0 1
0721 aaaaaaaaaaaaaaaa 5555555555555555 00 0 0000000000000001 00 2 0 1
0721 aaaaaaaaaaaaaaaa 5555555555555555 20 0 0000000000000000 00 2 0 1
0921 aaaaaaaaaaaaaaaa 5555555555555555 02 0 0000000000000001 00 2 0 1
0921 aaaaaaaaaaaaaaaa 5555555555555555 14 0 0000000000000000 00 2 0 1
0b21 aaaaaaaaaaaaaaaa 5555555555555555 10 0 0000000000000001 00 2 0 1
0b21 aaaaaaaaaaaaaaaa 5555555555555555 14 0 0000000000000000 00 2 0 1
0d21 aaaaaaaaaaaaaaaa 5555555555555555 00 0 0000000000000001 00 2 0 1
0d21 aaaaaaaaaaaaaaaa 5555555555555555 10 0 0000000000000000 00 2 0 1
0f21 aaaaaaaaaaaaaaaa 5555555555555555 00 0 0000000000000001 00 2 0 1
2c00 0000000000000001 0000000000000001 00 0 0000000000000002 00 2 1 0
0c00 0000000000000001 0000000000000001 00 2 0000000000000002 00 2 1 0
0c00 0000000000000001 0000000000000001 00 0 0000000000000002 00 2 1 0
0c00 0000000000000001 0000000000000001 00 0 0000000000000002 00 2 1 1
0c00 0000000000000001 0000000000000001 00 3 0000000000000002 00 2 1 1
0c00 0000000000000001 0000000000000001 00 4 0000000000000002 00 2 1 0
0c00 0000000000000001 0000000000000001 00 4 0000000000000002 00 2 1 1
0c00 0000000000000001 0000000000000001 00 7 0000000000000002 00 2 1 0
0c00 0000000000000001 0000000000000001 00 0 0000000000000002 00 2 1 1
ffff 0 0 0 0 0 0 0 0 0

/* list.f */
+incdir+hdl
hdl/alu_pkg.sv
hdl/cond_eval.sv
hdl/alu_decode.sv
hdl/alu_datapath.sv
hdl/alu_retire.sv
hdl/alu_top.sv
verification/alu_tb.sv

/* Makefile */
# Verilator build and run for the ALU stage testbench
SIM    := verilator
FLAGS  := --binary --assert
TOP    := alu_tb
FLIST  := list.f
OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)
SRCS   := $(filter-out +%,$(shell cat $(FLIST))) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJDIR)

/* verification/alu_tb.sv */
// testbench for the ALU stage, replays the vector file one operation per cycle
// each vector's expected outputs are compared one cycle after it is driven
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_tb;

  localparam int NCOL    = 10;   // tokens per vector line
  localparam int MAX_VEC = 128;
  localparam int ADDR_W  = $clog2(NCOL * MAX_VEC);
  localparam logic [63:0] END_MARK = 64'hffff;

  logic                      clk;
  logic                      rst;
  logic                      in_valid;
  alu_pkg::alu_op_u          op;
  logic [`ALU_DATA_W-1:0]    a;
  logic [`ALU_DATA_W-1:0]    b;
  logic [`ALU_FLAGS_W-1:0]   flags_in;
  logic                      error;
  logic                      thread;
  logic                      except;
  logic                      except_thread;
  logic                      ret_en;
  logic [`ALU_DATA_W-1:0]    result;
  logic [`ALU_FLAGS_W-1:0]   flags;
  logic [`ALU_STATUS_W-1:0]  status;
  logic                      sets_flags_out;

  logic [63:0] vec_mem [0:NCOL*MAX_VEC-1];
  int          n_vec;
  int          cycles = 0;
  int          limit = 0;
  string       step;      // where the run is, for error lines

  alu_top dut_i (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .op             (op),
    .a              (a),
    .b              (b),
    .flags_in       (flags_in),
    .error          (error),
    .thread         (thread),
    .except         (except),
    .except_thread  (except_thread),
    .ret_en         (ret_en),
    .result         (result),
    .flags          (flags),
    .status         (status),
    .sets_flags_out (sets_flags_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [63:0] vec_field(input int idx, input int col);
    logic [ADDR_W-1:0] addr;
  begin
    addr      = ADDR_W'(idx * NCOL + col);
    vec_field = vec_mem[addr];
  end
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
  begin
    if (got !== exp)
    begin
      $display("Error at %0d ns: %s is %h, expected %h (%s)", $time, name, got, exp, step);
      $display("Test FAILED");
      $fatal(1, "output mismatch");
    end
  end
  endtask

  task automatic apply_vector(input int idx);
    logic [63:0] ctrl;
    logic [63:0] op_word;
    logic [63:0] fl_word;
  begin
    op_word       = vec_field(idx, 0);
    fl_word       = vec_field(idx, 3);
    ctrl          = vec_field(idx, 4);   // error, thread, except, except_thread
    in_valid      = 1'b1;
    op            = op_word[`ALU_OP_W-1:0];
    a             = vec_field(idx, 1);
    b             = vec_field(idx, 2);
    flags_in      = fl_word[`ALU_FLAGS_W-1:0];
    error         = ctrl[3];
    thread        = ctrl[2];
    except        = ctrl[1];
    except_thread = ctrl[0];
  end
  endtask

  task automatic check_vector(input int idx);
    logic [63:0] exp_ret;
    logic [63:0] exp_status;
  begin
    exp_ret    = vec_field(idx, 9);
    exp_status = vec_field(idx, 7);
    step       = $sformatf("vector %0d", idx);
    compare_value("ret_en", 64'(ret_en), exp_ret);
    // a dropped return defines nothing else
    if (exp_ret[0])
    begin
      compare_value("status", 64'(status), exp_status);
      compare_value("flags", 64'(flags), vec_field(idx, 6));
      if (exp_status[1:0] == `ALU_ST_DONE)   // result only on a clean finish
      begin
        compare_value("result", result, vec_field(idx, 5));
        compare_value("sets_flags_out", 64'(sets_flags_out), vec_field(idx, 8));
      end
    end
  end
  endtask

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit)
    begin
      $display("Test FAILED");
      $fatal(1, "timeout after %0d cycles, the vector loop never finished", cycles);
    end
  end

  initial
  begin
    rst           = 1'b1;
    in_valid      = 1'b0;
    op            = '0;
    a             = '0;
    b             = '0;
    flags_in      = '0;
    error         = 1'b0;
    thread        = 1'b0;
    except        = 1'b0;
    except_thread = 1'b0;
    step          = "load";
    $readmemh("verification/alu_vectors.txt", vec_mem);
    n_vec = 0;
    while (n_vec < MAX_VEC && vec_field(n_vec, 0) != END_MARK)
      n_vec++;
    if (n_vec == 0 || n_vec == MAX_VEC)
    begin
      $display("Test FAILED");
      $fatal(1, "vector file is missing, empty or has no end marker");
    end
    limit = n_vec + 20;

    repeat (3) @(posedge clk);
    #1;
    rst  = 1'b0;
    step = "reset";
    compare_value("ret_en", 64'(ret_en), 64'd0);
    compare_value("status", 64'(status), 64'(`ALU_ST_DONE));
    compare_value("result", result, 64'd0);
    compare_value("flags", 64'(flags), 64'd0);
    compare_value("sets_flags_out", 64'(sets_flags_out), 64'd0);

    // back to back, one op every cycle
    for (int i = 0; i < n_vec; i++)
    begin
      apply_vector(i);
      @(posedge clk);
      #1;
      check_vector(i);
    end
    in_valid = 1'b0;

    // an idle cycle returns nothing
    @(posedge clk);
    #1;
    step = "idle";
    compare_value("ret_en", 64'(ret_en), 64'd0);

    $display("Test OK");
    $finish;
  end

endmodule

/* hdl/alu_top.sv */
// single-issue integer ALU stage, one op per in_valid, registered result a cycle later
// decode, condition evaluation and datapath feed the retire register
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  alu_pkg::alu_op_u          op,
  input  logic [`ALU_DATA_W-1:0]    a,
  input  logic [`ALU_DATA_W-1:0]    b,
  input  logic [`ALU_FLAGS_W-1:0]   flags_in,
  input  logic                      error,
  input  logic                      thread,
  input  logic                      except,
  input  logic                      except_thread,
  output logic                      ret_en,
  output logic [`ALU_DATA_W-1:0]    result,
  output logic [`ALU_FLAGS_W-1:0]   flags,
  output logic [`ALU_STATUS_W-1:0]  status,
  output logic                      sets_flags_out
);

  alu_pkg::alu_unit_e          unit;
  logic                        is_sub;
  logic                        is_64;
  logic                        ext_signed;
  logic [1:0]                  ext_size;
  logic [1:0]                  logic_fn;
  logic [`ALU_COND_W-1:0]      cond;
  logic                        sets_flags;
  logic                        illegal;
  logic                        cond_true;
  logic [`ALU_DATA_W-1:0]      dp_result;
  logic [`ALU_FLAGS_W-1:0]     raw_flags;

  alu_decode decode_i (
    .clk        (clk),
    .op         (op),
    .unit       (unit),
    .is_sub     (is_sub),
    .is_64      (is_64),
    .ext_signed (ext_signed),
    .ext_size   (ext_size),
    .logic_fn   (logic_fn),
    .cond       (cond),
    .sets_flags (sets_flags),
    .illegal    (illegal)
  );

  cond_eval cond_i (
    .flags_in  (flags_in),
    .cond      (cond),
    .cond_true (cond_true)
  );

  alu_datapath datapath_i (
    .a          (a),
    .b          (b),
    .unit       (unit),
    .is_sub     (is_sub),
    .is_64      (is_64),
    .ext_signed (ext_signed),
    .ext_size   (ext_size),
    .logic_fn   (logic_fn),
    .cond_true  (cond_true),
    .result     (dp_result),
    .raw_flags  (raw_flags)
  );

  alu_retire retire_i (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .foreign       (op.sz.foreign),
    .result        (dp_result),
    .raw_flags     (raw_flags),
    .sets_flags    (sets_flags),
    .illegal       (illegal),
    .error         (error),
    .thread        (thread),
    .except        (except),
    .except_thread (except_thread),
    .ret_en        (ret_en),
    .result_q      (result),
    .flags_q       (flags),
    .status_q      (status),
    .sets_flags_q  (sets_flags_out)
  );

endmodule

/* hdl/alu_retire.sv */
// one register stage for result, flag field, status and sets-flags
// return strobe is dropped on foreign ops and recent same-thread exceptions
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_retire (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  logic                      foreign,
  input  logic [`ALU_DATA_W-1:0]    result,
  input  logic [`ALU_FLAGS_W-1:0]   raw_flags,
  input  logic                      sets_flags,
  input  logic                      illegal,
  input  logic                      error,
  input  logic                      thread,
  input  logic                      except,
  input  logic                      except_thread,
  output logic                      ret_en,
  output logic [`ALU_DATA_W-1:0]    result_q,
  output logic [`ALU_FLAGS_W-1:0]   flags_q,
  output logic [`ALU_STATUS_W-1:0]  status_q,
  output logic                      sets_flags_q
);

  logic                      except_q;
  logic                      except_thread_q;
  logic                      hit_now;
  logic                      hit_prev;
  logic                      inhibit;
  logic [`ALU_FLAGS_W-1:0]   flags_d;
  logic [`ALU_STATUS_W-1:0]  status_d;

  // same-thread exception this cycle or last
  assign hit_now  = except && (except_thread == thread);
  assign hit_prev = except_q && (except_thread_q == thread);
  assign inhibit  = hit_now | hit_prev;

  always_comb
  begin
    if (error)
    begin
      status_d = `ALU_ST_EXC;
      flags_d  = `ALU_EXC_ERROR;
    end
    else if (illegal)
    begin
      status_d = `ALU_ST_EXC;
      flags_d  = `ALU_EXC_ILLEGAL;
    end
    else
    begin
      status_d = `ALU_ST_DONE;
      flags_d  = sets_flags ? raw_flags : '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ret_en          <= 1'b0;
      sets_flags_q    <= 1'b0;
      status_q        <= `ALU_ST_DONE;
      result_q        <= '0;
      flags_q         <= '0;
      except_q        <= 1'b0;
      except_thread_q <= 1'b0;
    end
    else
    begin
      ret_en          <= in_valid & ~foreign & ~inhibit;
      sets_flags_q    <= in_valid & sets_flags;
      status_q        <= status_d;
      result_q        <= result;
      flags_q         <= flags_d;
      except_q        <= except;
      except_thread_q <= except_thread;
    end
  end

  a_exc_code: assert property (@(posedge clk) disable iff (rst)
    status_q == `ALU_ST_EXC |-> flags_q == `ALU_EXC_ILLEGAL || flags_q == `ALU_EXC_ERROR);

  a_quiet_after_reset: assert property (@(posedge clk) rst |=> !ret_en);

endmodule

/* hdl/alu_datapath.sv */
// adder, logic unit, extender and conditional select with the result mux
// also forms the raw COASZP flags at the selected width, combinational
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_datapath (
  input  logic [`ALU_DATA_W-1:0]   a,
  input  logic [`ALU_DATA_W-1:0]   b,
  input  alu_pkg::alu_unit_e       unit,
  input  logic                     is_sub,
  input  logic                     is_64,
  input  logic                     ext_signed,
  input  logic [1:0]               ext_size,
  input  logic [1:0]               logic_fn,
  input  logic                     cond_true,
  output logic [`ALU_DATA_W-1:0]   result,
  output logic [`ALU_FLAGS_W-1:0]  raw_flags
);

  localparam int W = `ALU_DATA_W;
  localparam int H = `ALU_DATA_W / 2;

  logic [W-1:0] b_op;
  logic [W:0]   sum;
  logic         c4;
  logic         c32;
  logic         c64;
  logic [W-1:0] logic_res;
  logic [W-1:0] ext_res;
  logic [W-1:0] csel_res;
  logic [W-1:0] full;
  logic         narrow;
  logic         is_arith;
  logic         a_s;
  logic         b_s;
  logic         r_s;
  logic         carry;
  logic         ovf;
  logic         nib;
  logic         zero;
  logic         parity;

  // sub is a + ~b + 1
  assign b_op = is_sub ? ~b : b;
  assign sum  = {1'b0, a} + {1'b0, b_op} + {{W{1'b0}}, is_sub};

  // carry into bits 4 and 32 recovered from the sum bits
  assign c4  = sum[4] ^ a[4] ^ b_op[4];
  assign c32 = sum[H] ^ a[H] ^ b_op[H];
  assign c64 = sum[W];

  always_comb
  begin
    case (logic_fn)
      2'd0:    logic_res = a & b;
      2'd1:    logic_res = a | b;
      2'd2:    logic_res = a ^ b;
      default: logic_res = ~(a ^ b);
    endcase
  end

  always_comb
  begin
    case (ext_size)
      2'd0:    ext_res = {{(W-8){ext_signed & b[7]}}, b[7:0]};
      2'd1:    ext_res = {{(W-16){ext_signed & b[15]}}, b[15:0]};
      default: ext_res = {{(W-32){ext_signed & b[31]}}, b[31:0]};
    endcase
  end

  assign csel_res = logic_fn[0] ? {{(W-1){1'b0}}, cond_true} : (cond_true ? b : a);

  always_comb
  begin
    case (unit)
      alu_pkg::ADD:   full = sum[W-1:0];
      alu_pkg::LOGIC: full = logic_res;
      alu_pkg::EXT:   full = ext_res;
      alu_pkg::CSEL:  full = csel_res;
      default:        full = '0;
    endcase
  end

  // 32-bit arith and logic clear the upper half
  assign is_arith = (unit == alu_pkg::ADD);
  assign narrow   = (is_arith || unit == alu_pkg::LOGIC) && !is_64;
  assign result   = narrow ? {{H{1'b0}}, full[H-1:0]} : full;

  assign a_s = is_64 ? a[W-1] : a[H-1];
  assign b_s = is_64 ? b_op[W-1] : b_op[H-1];
  assign r_s = is_64 ? result[W-1] : result[H-1];

  // same-sign inputs, other-sign result; b_op covers sub too
  assign ovf    = is_arith & (a_s == b_s) & (r_s != a_s);
  assign carry  = is_arith & (is_64 ? c64 : c32);
  assign nib    = is_arith & (c4 ^ is_sub);   // inverted on sub
  assign zero   = ~|result;
  assign parity = ~^result[7:0];

  assign raw_flags = {carry, ovf, nib, r_s, zero, parity};

endmodule

/* hdl/alu_decode.sv */
// splits the operation word into unit select, width, condition and legality
// purely combinational, clk only clocks the check below
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_decode (
  input  logic                    clk,
  input  alu_pkg::alu_op_u        op,
  output alu_pkg::alu_unit_e      unit,
  output logic                    is_sub,
  output logic                    is_64,
  output logic                    ext_signed,
  output logic [1:0]              ext_size,
  output logic [1:0]              logic_fn,
  output logic [`ALU_COND_W-1:0]  cond,
  output logic                    sets_flags,
  output logic                    illegal
);

  logic [7:0] code;
  logic [1:0] size;
  logic       wide_ok;   // 32 or 64 bits

  assign code     = op.sz.code;
  assign size     = op.sz.size;
  assign wide_ok  = size[1];
  assign is_64    = (size == 2'd3);
  assign ext_size = size;      // source width for zxt/sxt
  assign cond     = op.cc.cond;

  always_comb
  begin
    unit       = alu_pkg::NONE;
    is_sub     = 1'b0;
    ext_signed = 1'b0;
    logic_fn   = 2'd0;
    sets_flags = 1'b0;
    illegal    = 1'b0;
    case (code)
      `ALU_OP_ADD, `ALU_OP_SUB:
      begin
        unit       = alu_pkg::ADD;
        is_sub     = (code == `ALU_OP_SUB);
        sets_flags = 1'b1;
        illegal    = ~wide_ok;
      end
      `ALU_OP_AND, `ALU_OP_OR, `ALU_OP_XOR, `ALU_OP_XNOR:
      begin
        unit       = alu_pkg::LOGIC;
        logic_fn   = code[1:0];  // and, or, xor, xnor
        sets_flags = 1'b1;
        illegal    = ~wide_ok;
      end
      `ALU_OP_ZXT, `ALU_OP_SXT:
      begin
        unit       = alu_pkg::EXT;
        ext_signed = (code == `ALU_OP_SXT);
        illegal    = is_64;      // nothing to extend from 64
      end
      `ALU_OP_CMOV, `ALU_OP_CSET:
      begin
        unit     = alu_pkg::CSEL;
        logic_fn = {1'b0, code == `ALU_OP_CSET}; // bit 0 picks cset over cmov
      end
      default: illegal = 1'b1;
    endcase

    if (illegal)
    begin
      unit       = alu_pkg::NONE;
      sets_flags = 1'b0;
    end
    else if (op.sz.no_flags)
    begin
      sets_flags = 1'b0;
    end
  end

  // retire relies on a dead datapath for illegal ops
  a_illegal_no_unit: assert property (@(posedge clk) illegal |-> unit == alu_pkg::NONE);

endmodule

/* hdl/cond_eval.sv */
// evaluates a 4-bit condition code against the incoming COASZP flags
// used by cmov and cset, combinational
`timescale 1ns/1ps
`include "alu_config.svh"

module cond_eval (
  input  logic [`ALU_FLAGS_W-1:0] flags_in,
  input  logic [`ALU_COND_W-1:0]  cond,
  output logic                    cond_true
);

  logic c, o, s, z, p;

  // nibble carry takes part in no condition
  assign {c, o}    = flags_in[5:4];
  assign {s, z, p} = flags_in[2:0];

  always_comb
  begin
    cond_true = 1'b1;
    case (cond)
      `ALU_CC_Z:      cond_true = z;
      `ALU_CC_NZ:     cond_true = ~z;
      `ALU_CC_S:      cond_true = s;
      `ALU_CC_NS:     cond_true = ~s;
      `ALU_CC_UGT:    cond_true = c & ~z;     // unsigned on carry and zero
      `ALU_CC_ULE:    cond_true = ~c | z;
      `ALU_CC_UGE:    cond_true = c;
      `ALU_CC_ULT:    cond_true = ~c;
      `ALU_CC_SGT:    cond_true = ~((s ^ o) | z);
      `ALU_CC_SLE:    cond_true = (s ^ o) | z;
      `ALU_CC_SGE:    cond_true = ~(s ^ o);
      `ALU_CC_SLT:    cond_true = s ^ o;
      `ALU_CC_O:      cond_true = o;
      `ALU_CC_NO:     cond_true = ~o;
      `ALU_CC_P:      cond_true = p;
      `ALU_CC_ALWAYS: cond_true = 1'b1;
      default:        cond_true = 1'b1;
    endcase
  end

endmodule

/* hdl/alu_pkg.sv */
// types shared by the ALU stage: the operation word and the result unit select
// referenced by scoped names, compile before the RTL modules
`include "alu_config.svh"

package alu_pkg;

  // operation word seen as size-carrying ops (add, logic, extend)
  typedef struct packed {
    logic                  foreign;   // op belongs to another unit
    logic                  no_flags;
    logic [1:0]            size;      // 0=8 1=16 2=32 3=64
    logic [`ALU_OP_W-13:0] spare;
    logic [7:0]            code;
  } alu_op_sized_t;

  // same word seen as a conditional op (cmov, cset)
  typedef struct packed {
    logic                   foreign;
    logic                   no_flags;
    logic [`ALU_COND_W-1:0] cond;
    logic [7:0]             code;
  } alu_op_cond_t;

  // one word, two decodings
  typedef union packed {
    alu_op_sized_t sz;
    alu_op_cond_t  cc;
  } alu_op_u;

  // unit that owns the result
  typedef enum logic [2:0] {
    ADD,
    LOGIC,
    EXT,
    CSEL,
    NONE
  } alu_unit_e;

endpackage

/* hdl/alu_config.svh */
// shared widths and code points for the integer ALU stage
// include wherever a width, opcode, condition or status code is needed
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

`define ALU_DATA_W      64
`define ALU_OP_W        14
`define ALU_FLAGS_W     6   // C O A S Z P
`define ALU_COND_W      4
`define ALU_STATUS_W    2

`define ALU_EXC_ILLEGAL 6'd11
`define ALU_EXC_ERROR   6'd63
`define ALU_ST_DONE     2'd2
`define ALU_ST_EXC      2'd1

`define ALU_OP_ADD      8'h00
`define ALU_OP_SUB      8'h01
`define ALU_OP_AND      8'h04
`define ALU_OP_OR       8'h05
`define ALU_OP_XOR      8'h06
`define ALU_OP_XNOR     8'h07
`define ALU_OP_ZXT      8'h10
`define ALU_OP_SXT      8'h11
`define ALU_OP_CMOV     8'h20
`define ALU_OP_CSET     8'h21

`define ALU_CC_Z        4'd0
`define ALU_CC_NZ       4'd1
`define ALU_CC_S        4'd2
`define ALU_CC_NS       4'd3
`define ALU_CC_UGT      4'd4
`define ALU_CC_ULE      4'd5
`define ALU_CC_UGE      4'd6
`define ALU_CC_ULT      4'd7
`define ALU_CC_SGT      4'd8
`define ALU_CC_SLE      4'd9
`define ALU_CC_SGE      4'd10
`define ALU_CC_SLT      4'd11
`define ALU_CC_O        4'd12
`define ALU_CC_NO       4'd13
`define ALU_CC_P        4'd14
`define ALU_CC_ALWAYS   4'd15

`endif
